//--- hw/soc_ifc_pkg.sv
// SoC interface register map and boot definitions
// APB widths, register offsets, generic wire bundle and boot sequencer
// states shared by the register block and the boot FSM

package soc_ifc_pkg;

    // ------------------------------------------------------------------
    // APB bus
    // ------------------------------------------------------------------
    localparam int APB_ADDR_W = 12;
    localparam int APB_DATA_W = 32;

    typedef logic [APB_ADDR_W-1:0] apb_addr_t;   // Byte offset inside the block
    typedef logic [APB_DATA_W-1:0] apb_data_t;

    // ------------------------------------------------------------------
    // Register map
    // ------------------------------------------------------------------
    localparam apb_addr_t ADDR_FLOW_STATUS   = 12'h000;
    localparam apb_addr_t ADDR_FUSE_DONE     = 12'h004;
    localparam apb_addr_t ADDR_GEN_OUT_LO    = 12'h008;
    localparam apb_addr_t ADDR_GEN_OUT_HI    = 12'h00C;
    localparam apb_addr_t ADDR_GEN_IN_LO     = 12'h010;   // Read only
    localparam apb_addr_t ADDR_GEN_IN_HI     = 12'h014;   // Read only
    localparam apb_addr_t ADDR_MBOX_DOORBELL = 12'h018;
    localparam apb_addr_t ADDR_INTR_EN       = 12'h01C;
    localparam apb_addr_t ADDR_INTR_STATUS   = 12'h020;

    // Mailbox window runs from here to the top of the space
    localparam apb_addr_t MBOX_WINDOW_BASE   = 12'h800;

    // Generic wires
    localparam int GEN_WIRES_W = 64;

    typedef logic [GEN_WIRES_W-1:0] gen_wires_t;

    // ------------------------------------------------------------------
    // Boot sequencing
    // ------------------------------------------------------------------
    typedef enum logic [1:0] {
        BOOT_IDLE,
        BOOT_FUSE,
        BOOT_WAIT,
        BOOT_DONE
    } boot_state_e;

    localparam int UC_RST_DELAY = 16;   // Cycles from fuse done to reset release
    localparam int UC_RST_CNT_W = $clog2(UC_RST_DELAY + 1);

    typedef logic [UC_RST_CNT_W-1:0] uc_rst_cnt_t;

endpackage

//--- hw/mbox_pkg.sv
// Mailbox SRAM definitions
// Word address and data types plus the request and response bundles
// between the register block, the mailbox controller and the SRAM

package mbox_pkg;

    localparam int MBOX_ADDR_W = 9;    // 512 words behind the window
    localparam int MBOX_DATA_W = 32;

    typedef logic [MBOX_ADDR_W-1:0] mbox_addr_t;
    typedef logic [MBOX_DATA_W-1:0] mbox_data_t;

    // Window access from the APB side
    typedef struct packed {
        logic       valid;
        logic       write;
        mbox_addr_t addr;    // Word address
        mbox_data_t wdata;
    } mbox_req_t;

    typedef struct packed {
        logic       ack;     // Ends the APB access
        mbox_data_t rdata;
    } mbox_resp_t;

    // Single port SRAM strobe
    typedef struct packed {
        logic       cs;
        logic       we;
        mbox_addr_t addr;
        mbox_data_t wdata;
    } mbox_sram_req_t;

endpackage

//--- hw/soc_ifc_regs.sv
// SoC interface register block
// APB slave with flow status, fuse done, generic wires, doorbell and
// interrupt registers; window accesses are handed to the mailbox controller

`timescale 1ns/1ps

module soc_ifc_regs (
    input  logic                     clk,
    input  logic                     rst_n_i,

    // APB from the SoC
    input  soc_ifc_pkg::apb_addr_t   paddr_i,
    input  logic                     psel_i,
    input  logic                     penable_i,
    input  logic                     pwrite_i,
    input  soc_ifc_pkg::apb_data_t   pwdata_i,
    output logic                     pready_o,
    output soc_ifc_pkg::apb_data_t   prdata_o,
    output logic                     pslverr_o,

    input  soc_ifc_pkg::gen_wires_t  generic_input_wires_i,
    output soc_ifc_pkg::gen_wires_t  generic_output_wires_o,

    output logic                     ready_for_fw_push_o,
    output logic                     ready_for_runtime_o,
    output logic                     mailbox_flow_done_o,
    output logic                     mailbox_data_avail_o,

    output logic                     error_intr_o,
    output logic                     notif_intr_o,

    // Boot sequencer
    output logic                     fuse_done_o,
    input  soc_ifc_pkg::boot_state_e boot_state_i,

    // Mailbox controller
    output mbox_pkg::mbox_req_t      mbox_req_o,
    input  mbox_pkg::mbox_resp_t     mbox_resp_i
);

    logic                    acc;          // APB access phase
    logic                    win_sel;
    logic                    reg_hit;
    logic                    reg_ro;
    logic                    dec_err;
    logic                    reg_wr;
    logic                    err_evt;
    logic                    notif_evt;
    logic                    intr_clr;
    soc_ifc_pkg::apb_data_t  reg_rdata;

    logic [2:0]              flow_sts_q;
    logic                    doorbell_q;
    logic                    err_en_q;
    logic                    notif_en_q;
    logic                    err_sts_q;
    logic                    notif_sts_q;
    soc_ifc_pkg::gen_wires_t gen_out_q;

    // ------------------------------------------------------------------
    // Address decode and read mux
    // ------------------------------------------------------------------
    assign acc     = psel_i & penable_i;
    assign win_sel = (paddr_i >= soc_ifc_pkg::MBOX_WINDOW_BASE);

    always_comb begin
        reg_hit   = 1'b1;
        reg_ro    = 1'b0;
        reg_rdata = '0;
        case (paddr_i)
            soc_ifc_pkg::ADDR_FLOW_STATUS:   reg_rdata = soc_ifc_pkg::apb_data_t'(flow_sts_q);
            soc_ifc_pkg::ADDR_FUSE_DONE: begin
                reg_rdata = soc_ifc_pkg::apb_data_t'(boot_state_i == soc_ifc_pkg::BOOT_DONE);
            end
            soc_ifc_pkg::ADDR_GEN_OUT_LO: begin
                reg_rdata = gen_out_q[soc_ifc_pkg::APB_DATA_W-1:0];
            end
            soc_ifc_pkg::ADDR_GEN_OUT_HI: begin
                reg_rdata = gen_out_q[soc_ifc_pkg::GEN_WIRES_W-1:soc_ifc_pkg::APB_DATA_W];
            end
            soc_ifc_pkg::ADDR_GEN_IN_LO: begin
                reg_ro    = 1'b1;
                reg_rdata = generic_input_wires_i[soc_ifc_pkg::APB_DATA_W-1:0];
            end
            soc_ifc_pkg::ADDR_GEN_IN_HI: begin
                reg_ro    = 1'b1;
                reg_rdata = generic_input_wires_i[soc_ifc_pkg::GEN_WIRES_W-1:
                                                  soc_ifc_pkg::APB_DATA_W];
            end
            soc_ifc_pkg::ADDR_MBOX_DOORBELL: reg_rdata = soc_ifc_pkg::apb_data_t'(doorbell_q);
            soc_ifc_pkg::ADDR_INTR_EN: begin
                reg_rdata = soc_ifc_pkg::apb_data_t'({notif_en_q, err_en_q});
            end
            soc_ifc_pkg::ADDR_INTR_STATUS: begin
                reg_rdata = soc_ifc_pkg::apb_data_t'({notif_sts_q, err_sts_q});
            end
            default: reg_hit = 1'b0;
        endcase
    end

    // Unmapped offset or write to an input register
    assign dec_err   = ~win_sel & (~reg_hit | (reg_ro & pwrite_i));
    assign err_evt   = acc & dec_err;
    assign reg_wr    = acc & ~win_sel & pwrite_i & ~dec_err;
    assign intr_clr  = reg_wr & (paddr_i == soc_ifc_pkg::ADDR_INTR_STATUS);
    assign notif_evt = reg_wr & (paddr_i == soc_ifc_pkg::ADDR_MBOX_DOORBELL) & pwdata_i[0];

    assign fuse_done_o = reg_wr & (paddr_i == soc_ifc_pkg::ADDR_FUSE_DONE) & pwdata_i[0];

    // Window reads wait for the controller ack, everything else is zero wait
    assign pready_o  = acc & (~win_sel | mbox_resp_i.ack);
    assign pslverr_o = err_evt;
    assign prdata_o  = win_sel ? mbox_resp_i.rdata : reg_rdata;

    // ------------------------------------------------------------------
    // Mailbox window request
    // ------------------------------------------------------------------
    assign mbox_req_o.valid = acc & win_sel;
    assign mbox_req_o.write = pwrite_i;
    assign mbox_req_o.addr  = mbox_pkg::mbox_addr_t'((paddr_i - soc_ifc_pkg::MBOX_WINDOW_BASE)
                                                      >> 2);
    assign mbox_req_o.wdata = pwdata_i;

    // ------------------------------------------------------------------
    // Register storage
    // ------------------------------------------------------------------
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            flow_sts_q  <= '0;
            doorbell_q  <= 1'b0;
            err_en_q    <= 1'b0;
            notif_en_q  <= 1'b0;
            err_sts_q   <= 1'b0;
            notif_sts_q <= 1'b0;
            gen_out_q   <= '0;
        end else begin
            if (reg_wr) begin
                case (paddr_i)
                    soc_ifc_pkg::ADDR_FLOW_STATUS:   flow_sts_q <= pwdata_i[2:0];
                    soc_ifc_pkg::ADDR_GEN_OUT_LO: begin
                        gen_out_q[soc_ifc_pkg::APB_DATA_W-1:0] <= pwdata_i;
                    end
                    soc_ifc_pkg::ADDR_GEN_OUT_HI: begin
                        gen_out_q[soc_ifc_pkg::GEN_WIRES_W-1:soc_ifc_pkg::APB_DATA_W] <= pwdata_i;
                    end
                    soc_ifc_pkg::ADDR_MBOX_DOORBELL: doorbell_q <= pwdata_i[0];
                    soc_ifc_pkg::ADDR_INTR_EN:       {notif_en_q, err_en_q} <= pwdata_i[1:0];
                    default: ;
                endcase
            end
            // W1C, a new event in the same cycle wins
            err_sts_q   <= err_evt | (err_sts_q & ~(intr_clr & pwdata_i[0]));
            notif_sts_q <= notif_evt | (notif_sts_q & ~(intr_clr & pwdata_i[1]));
        end
    end

    assign ready_for_fw_push_o    = flow_sts_q[0];
    assign ready_for_runtime_o    = flow_sts_q[1];
    assign mailbox_flow_done_o    = flow_sts_q[2];
    assign mailbox_data_avail_o   = doorbell_q;
    assign generic_output_wires_o = gen_out_q;

    assign error_intr_o = err_sts_q & err_en_q;
    assign notif_intr_o = notif_sts_q & notif_en_q;

endmodule

//--- hw/soc_ifc_boot_fsm.sv
// Boot sequencer
// Waits for fuse programming, then counts a fixed delay while the boot
// breakpoint is clear and finally releases the microcontroller reset

`timescale 1ns/1ps

module soc_ifc_boot_fsm (
    input  logic                     clk,
    input  logic                     rst_n_i,
    input  logic                     fuse_done_i,      // One cycle pulse
    input  logic                     boot_brkpoint_i,
    output soc_ifc_pkg::boot_state_e boot_state_o,
    output logic                     ready_for_fuses_o,
    output logic                     uc_rst_b_o
);

    soc_ifc_pkg::boot_state_e state_q, state_d;
    soc_ifc_pkg::uc_rst_cnt_t cnt_q, cnt_d;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q <= soc_ifc_pkg::BOOT_IDLE;
            cnt_q   <= '0;
        end else begin
            state_q <= state_d;
            cnt_q   <= cnt_d;
        end
    end

    always_comb begin
        state_d = state_q;
        cnt_d   = cnt_q;
        case (state_q)
            soc_ifc_pkg::BOOT_IDLE: state_d = soc_ifc_pkg::BOOT_FUSE;
            soc_ifc_pkg::BOOT_FUSE: begin
                if (fuse_done_i) begin
                    state_d = soc_ifc_pkg::BOOT_WAIT;
                    cnt_d   = '0;
                end
            end
            soc_ifc_pkg::BOOT_WAIT: begin
                // Breakpoint freezes the count
                if (!boot_brkpoint_i) begin
                    if (cnt_q == soc_ifc_pkg::uc_rst_cnt_t'(soc_ifc_pkg::UC_RST_DELAY - 1)) begin
                        state_d = soc_ifc_pkg::BOOT_DONE;
                    end else begin
                        cnt_d = cnt_q + 1'b1;
                    end
                end
            end
            soc_ifc_pkg::BOOT_DONE: ;   // Stays here until reset
            default: state_d = soc_ifc_pkg::BOOT_IDLE;
        endcase
    end

    assign boot_state_o      = state_q;
    assign ready_for_fuses_o = (state_q == soc_ifc_pkg::BOOT_FUSE);
    assign uc_rst_b_o        = (state_q == soc_ifc_pkg::BOOT_DONE);

endmodule

//--- hw/mbox_sram_ctrl.sv
// Mailbox SRAM access engine
// Turns window requests into one-cycle SRAM strobes; writes ack at once,
// reads ack one cycle later when the SRAM data is back

`timescale 1ns/1ps

module mbox_sram_ctrl (
    input  logic                     clk,
    input  logic                     rst_n_i,
    input  mbox_pkg::mbox_req_t      mbox_req_i,
    output mbox_pkg::mbox_resp_t     mbox_resp_o,
    output mbox_pkg::mbox_sram_req_t mbox_sram_req_o,
    input  mbox_pkg::mbox_data_t     mbox_sram_rdata_i
);

    logic rd_pend_q;   // SRAM read issued last cycle
    logic rd_start;

    // ------------------------------------------------------------------
    // SRAM strobe
    // ------------------------------------------------------------------
    // Request stays valid through the wait state, so mask the repeat strobe
    assign mbox_sram_req_o.cs    = mbox_req_i.valid & ~rd_pend_q;
    assign mbox_sram_req_o.we    = mbox_req_i.write;
    assign mbox_sram_req_o.addr  = mbox_req_i.addr;
    assign mbox_sram_req_o.wdata = mbox_req_i.wdata;

    assign rd_start = mbox_req_i.valid & ~mbox_req_i.write & ~rd_pend_q;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            rd_pend_q <= 1'b0;
        end else begin
            rd_pend_q <= rd_start;   // Clears itself after the ack cycle
        end
    end

    // ------------------------------------------------------------------
    // Response
    // ------------------------------------------------------------------
    assign mbox_resp_o.ack   = (mbox_req_i.valid & mbox_req_i.write) | rd_pend_q;
    assign mbox_resp_o.rdata = mbox_sram_rdata_i;

endmodule

//--- hw/soc_ifc_top.sv
// SoC interface top level
// Connects the APB register block, the boot sequencer and the mailbox
// SRAM controller

`timescale 1ns/1ps

module soc_ifc_top (
    input  logic                     clk,
    input  logic                     rst_n_i,

    // APB from the SoC
    input  soc_ifc_pkg::apb_addr_t   paddr_i,
    input  logic                     psel_i,
    input  logic                     penable_i,
    input  logic                     pwrite_i,
    input  soc_ifc_pkg::apb_data_t   pwdata_i,
    output logic                     pready_o,
    output soc_ifc_pkg::apb_data_t   prdata_o,
    output logic                     pslverr_o,

    input  soc_ifc_pkg::gen_wires_t  generic_input_wires_i,
    output soc_ifc_pkg::gen_wires_t  generic_output_wires_o,

    // Boot and flow status
    input  logic                     boot_brkpoint_i,
    output logic                     ready_for_fuses_o,
    output logic                     ready_for_fw_push_o,
    output logic                     ready_for_runtime_o,
    output logic                     mailbox_data_avail_o,
    output logic                     mailbox_flow_done_o,
    output logic                     uc_rst_b_o,

    output logic                     error_intr_o,
    output logic                     notif_intr_o,

    // Mailbox SRAM
    output mbox_pkg::mbox_sram_req_t mbox_sram_req_o,
    input  mbox_pkg::mbox_data_t     mbox_sram_rdata_i
);

    logic                     fuse_done;
    soc_ifc_pkg::boot_state_e boot_state;
    mbox_pkg::mbox_req_t      mbox_req;
    mbox_pkg::mbox_resp_t     mbox_resp;

    // ------------------------------------------------------------------
    // Register block
    // ------------------------------------------------------------------
    soc_ifc_regs u_regs (
        .clk                    (clk),
        .rst_n_i                (rst_n_i),
        .paddr_i                (paddr_i),
        .psel_i                 (psel_i),
        .penable_i              (penable_i),
        .pwrite_i               (pwrite_i),
        .pwdata_i               (pwdata_i),
        .pready_o               (pready_o),
        .prdata_o               (prdata_o),
        .pslverr_o              (pslverr_o),
        .generic_input_wires_i  (generic_input_wires_i),
        .generic_output_wires_o (generic_output_wires_o),
        .ready_for_fw_push_o    (ready_for_fw_push_o),
        .ready_for_runtime_o    (ready_for_runtime_o),
        .mailbox_flow_done_o    (mailbox_flow_done_o),
        .mailbox_data_avail_o   (mailbox_data_avail_o),
        .error_intr_o           (error_intr_o),
        .notif_intr_o           (notif_intr_o),
        .fuse_done_o            (fuse_done),
        .boot_state_i           (boot_state),
        .mbox_req_o             (mbox_req),
        .mbox_resp_i            (mbox_resp)
    );

    // Boot sequencer
    soc_ifc_boot_fsm u_boot_fsm (
        .clk               (clk),
        .rst_n_i           (rst_n_i),
        .fuse_done_i       (fuse_done),
        .boot_brkpoint_i   (boot_brkpoint_i),
        .boot_state_o      (boot_state),
        .ready_for_fuses_o (ready_for_fuses_o),
        .uc_rst_b_o        (uc_rst_b_o)
    );

    // Mailbox window engine
    mbox_sram_ctrl u_mbox_ctrl (
        .clk               (clk),
        .rst_n_i           (rst_n_i),
        .mbox_req_i        (mbox_req),
        .mbox_resp_o       (mbox_resp),
        .mbox_sram_req_o   (mbox_sram_req_o),
        .mbox_sram_rdata_i (mbox_sram_rdata_i)
    );

endmodule

//--- verif/soc_ifc_props.sv
// SoC interface protocol checks
// APB ready timing, single-cycle SRAM strobes and a sticky
// microcontroller reset release

`timescale 1ns/1ps

module soc_ifc_props (
    input logic                     clk,
    input logic                     rst_n_i,
    input logic                     psel_i,
    input logic                     penable_i,
    input logic                     pready_o,
    input logic                     uc_rst_b_o,
    input mbox_pkg::mbox_sram_req_t mbox_sram_req_o
);

    // Ready only inside an access phase
    pready_in_access: assert property (
        @(posedge clk) disable iff (!rst_n_i) pready_o |-> (psel_i && penable_i)
    ) else $error("pready_o high outside an APB access phase");

    sram_cs_single: assert property (
        @(posedge clk) disable iff (!rst_n_i) mbox_sram_req_o.cs |=> !mbox_sram_req_o.cs
    ) else $error("SRAM chip select held for more than one cycle");

    uc_rst_sticky: assert property (
        @(posedge clk) disable iff (!rst_n_i) uc_rst_b_o |=> uc_rst_b_o
    ) else $error("uc_rst_b_o fell after the reset release");   // No way back to reset

endmodule

//--- verif/soc_ifc_tb.sv
// SoC interface testbench
// Replays the APB trace against the DUT, models the mailbox SRAM and
// compares bus responses, status outputs and SRAM contents with the trace

`timescale 1ns/1ps

module soc_ifc_tb;

    localparam int    RST_CYCLES = 16;
    localparam int    SRAM_WORDS = 1 << mbox_pkg::MBOX_ADDR_W;
    localparam string TRACE_FILE = "verif/soc_ifc_trace.txt";

    // One trace line
    typedef struct packed {
        logic [15:0]             op;      // Two ASCII characters
        soc_ifc_pkg::apb_addr_t  addr;
        soc_ifc_pkg::apb_data_t  data;    // Write data, read data or cycle count
        logic                    perr;
        soc_ifc_pkg::gen_wires_t gin;
        logic                    brk;
        logic [7:0]              flags;
        soc_ifc_pkg::gen_wires_t gout;
    } trace_op_t;

    logic                     clk = 1'b0;
    logic                     rst_n_i;
    soc_ifc_pkg::apb_addr_t   paddr_i;
    logic                     psel_i;
    logic                     penable_i;
    logic                     pwrite_i;
    soc_ifc_pkg::apb_data_t   pwdata_i;
    logic                     pready_o;
    soc_ifc_pkg::apb_data_t   prdata_o;
    logic                     pslverr_o;
    soc_ifc_pkg::gen_wires_t  generic_input_wires_i;
    soc_ifc_pkg::gen_wires_t  generic_output_wires_o;
    logic                     boot_brkpoint_i;
    logic                     ready_for_fuses_o;
    logic                     ready_for_fw_push_o;
    logic                     ready_for_runtime_o;
    logic                     mailbox_data_avail_o;
    logic                     mailbox_flow_done_o;
    logic                     uc_rst_b_o;
    logic                     error_intr_o;
    logic                     notif_intr_o;
    mbox_pkg::mbox_sram_req_t mbox_sram_req_o;
    mbox_pkg::mbox_data_t     mbox_sram_rdata_i = '0;

    mbox_pkg::mbox_data_t     sram [SRAM_WORDS];
    trace_op_t                ops[$];
    logic [7:0]               flags_now;
    int                       mismatches  = 0;
    int                       other_errs  = 0;
    int                       cycle_cnt   = 0;
    int                       cycle_limit = 0;

    always #4 clk = ~clk;   // 8 ns period

    assign flags_now = {notif_intr_o, error_intr_o, uc_rst_b_o, mailbox_data_avail_o,
                        mailbox_flow_done_o, ready_for_runtime_o, ready_for_fw_push_o,
                        ready_for_fuses_o};

    soc_ifc_top DUT (.*);

    bind soc_ifc_top soc_ifc_props u_props (
        .clk             (clk),
        .rst_n_i         (rst_n_i),
        .psel_i          (psel_i),
        .penable_i       (penable_i),
        .pready_o        (pready_o),
        .uc_rst_b_o      (uc_rst_b_o),
        .mbox_sram_req_o (mbox_sram_req_o)
    );

    // ------------------------------------------------------------------
    // Mailbox SRAM model with read data one cycle after the strobe
    // ------------------------------------------------------------------
    always @(posedge clk) begin
        if (!rst_n_i) begin
            for (int i = 0; i < SRAM_WORDS; i++) begin
                sram[mbox_pkg::mbox_addr_t'(i)] <= 32'hCAFE_0000 | 32'(i);   // Address in low bits
            end
        end else if (mbox_sram_req_o.cs) begin
            if (mbox_sram_req_o.we) begin
                sram[mbox_sram_req_o.addr] <= mbox_sram_req_o.wdata;
            end else begin
                mbox_sram_rdata_i <= sram[mbox_sram_req_o.addr];
            end
        end
    end

    // Run length guard
    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_limit != 0 && cycle_cnt >= cycle_limit) begin
            $display("Timeout: the trace did not finish within %0d cycles", cycle_limit);
            $display("Errors: %0d value, %0d other", mismatches, other_errs + 1);
            $display("STATUS: FAIL");
            $finish;
        end
    end

    // ------------------------------------------------------------------
    // Helpers
    // ------------------------------------------------------------------
    task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
        if (got !== exp) begin
            $display("error: %s is 0x%h, expected 0x%h at %0t", name, got, exp, $time);
            mismatches++;
        end
    endtask

    task automatic load_trace(output logic ok);
        int                     fd;
        int                     n;
        int                     wait_sum;
        string                  line;
        logic [15:0]            op_s;
        soc_ifc_pkg::apb_addr_t addr;
        soc_ifc_pkg::apb_data_t data;
        logic                   perr;
        logic                   brk;
        logic [31:0]            gin_hi, gin_lo, gout_hi, gout_lo;
        logic [7:0]             flags;
        trace_op_t              t;
        wait_sum = 0;
        fd = $fopen(TRACE_FILE, "r");
        ok = (fd != 0);
        if (ok) begin
            while ($fgets(line, fd) != 0) begin
                if (line.len() < 2 || line[0] == "#") continue;
                n = $sscanf(line, "%s %h %h %h %h %h %h %h %h %h", op_s, addr, data, perr,
                            gin_hi, gin_lo, brk, flags, gout_hi, gout_lo);
                if (n != 10) begin
                    $display("Trace line could not be parsed: %s", line);
                    other_errs++;
                    continue;
                end
                t = '{op: op_s, addr: addr, data: data, perr: perr, gin: {gin_hi, gin_lo},
                      brk: brk, flags: flags, gout: {gout_hi, gout_lo}};
                if (op_s == "wt" || op_s == "po") wait_sum += int'(data);
                ops.push_back(t);
            end
            $fclose(fd);
            ok = (ops.size() > 0);
        end
        cycle_limit = RST_CYCLES + 4 * ops.size() + wait_sum + soc_ifc_pkg::UC_RST_DELAY;
    endtask

    // Setup cycle, then access cycles until pready_o
    task automatic apb_xfer(input logic wr, input soc_ifc_pkg::apb_addr_t addr,
                            input soc_ifc_pkg::apb_data_t wdata,
                            output soc_ifc_pkg::apb_data_t rdata, output logic err,
                            output int waits);
        @(posedge clk);
        psel_i    <= 1'b1;
        penable_i <= 1'b0;
        paddr_i   <= addr;
        pwrite_i  <= wr;
        pwdata_i  <= wdata;
        @(posedge clk);
        penable_i <= 1'b1;
        waits = 0;
        @(negedge clk);
        while (!pready_o) begin
            @(negedge clk);
            waits++;
        end
        rdata = prdata_o;
        err   = pslverr_o;
        @(posedge clk);
        psel_i    <= 1'b0;
        penable_i <= 1'b0;
    endtask

    // Waits up to limit cycles for the expected flags, then checks all outputs
    task automatic await_outputs(input trace_op_t t, input int limit);
        int n;
        n = 0;
        @(negedge clk);
        while (flags_now !== t.flags && n < limit) begin
            @(negedge clk);
            n++;
        end
        check("ready_for_fuses_o", 64'(ready_for_fuses_o), 64'(t.flags[0]));
        check("ready_for_fw_push_o", 64'(ready_for_fw_push_o), 64'(t.flags[1]));
        check("ready_for_runtime_o", 64'(ready_for_runtime_o), 64'(t.flags[2]));
        check("mailbox_flow_done_o", 64'(mailbox_flow_done_o), 64'(t.flags[3]));
        check("mailbox_data_avail_o", 64'(mailbox_data_avail_o), 64'(t.flags[4]));
        check("uc_rst_b_o", 64'(uc_rst_b_o), 64'(t.flags[5]));
        check("error_intr_o", 64'(error_intr_o), 64'(t.flags[6]));
        check("notif_intr_o", 64'(notif_intr_o), 64'(t.flags[7]));
        check("generic_output_wires_o", 64'(generic_output_wires_o), 64'(t.gout));
        @(posedge clk);
    endtask

    task automatic run_trace;
        trace_op_t              t;
        soc_ifc_pkg::apb_data_t rdata;
        logic                   err;
        int                     waits;
        int                     exp_waits;
        mbox_pkg::mbox_addr_t   idx;
        foreach (ops[i]) begin
            t = ops[i];
            generic_input_wires_i <= t.gin;
            boot_brkpoint_i       <= t.brk;
            case (t.op)
                "wr": begin
                    apb_xfer(1'b1, t.addr, t.data, rdata, err, waits);
                    check("pslverr_o", 64'(err), 64'(t.perr));
                    check("write wait states", 64'(waits), 64'd0);
                end
                "rd": begin
                    apb_xfer(1'b0, t.addr, '0, rdata, err, waits);
                    // Window reads take one wait state and all others none
                    exp_waits = (t.addr >= soc_ifc_pkg::MBOX_WINDOW_BASE) ? 1 : 0;
                    check("pslverr_o", 64'(err), 64'(t.perr));
                    check("read wait states", 64'(waits), 64'(exp_waits));
                    if (!t.perr) check("prdata_o", 64'(rdata), 64'(t.data));
                end
                "wt": begin
                    repeat (t.data) @(posedge clk);
                    await_outputs(t, 0);
                end
                "po": await_outputs(t, int'(t.data));
                "mc": begin
                    idx = mbox_pkg::mbox_addr_t'((t.addr - soc_ifc_pkg::MBOX_WINDOW_BASE) >> 2);
                    @(negedge clk);   // Last window write lands on the edge before
                    check($sformatf("sram[%0d]", idx), 64'(sram[idx]), 64'(t.data));
                    @(posedge clk);
                end
                default: begin
                    $display("Unknown trace operation %s", t.op);
                    other_errs++;
                end
            endcase
        end
    endtask

    // ------------------------------------------------------------------
    // Main sequence
    // ------------------------------------------------------------------
    initial begin
        logic trace_ok;
        rst_n_i               <= 1'b0;
        paddr_i               <= '0;
        psel_i                <= 1'b0;
        penable_i             <= 1'b0;
        pwrite_i              <= 1'b0;
        pwdata_i              <= '0;
        generic_input_wires_i <= '0;
        boot_brkpoint_i       <= 1'b0;
        load_trace(trace_ok);
        if (!trace_ok) begin
            $display("Trace file %s is missing or holds no operations", TRACE_FILE);
            $display("STATUS: FAIL");
            $finish;
        end else begin
            repeat (RST_CYCLES) @(posedge clk);
            rst_n_i <= 1'b1;
            run_trace();
            $display("Errors: %0d value, %0d other", mismatches, other_errs);
            if (mismatches == 0 && other_errs == 0) begin
                $display("STATUS: PASS");
            end else begin
                $display("STATUS: FAIL");
            end
            $finish;
        end
    end

endmodule

//--- verif/soc_ifc_trace.txt
# op addr data perr gin_hi gin_lo brk flags gout_hi gout_lo (all hex)
# op wr/rd APB access, wt wait data cycles, po poll up to data cycles, mc SRAM word at addr
# flags 0 fuses, 1 fw_push, 2 runtime, 3 flow_done, 4 data_avail, 5 uc_rst_b, 6 err, 7 notif
wt 000 00000001 0 00000000 00000000 0 01 00000000 00000000
wr 008 89abcdef 0 00000000 00000000 0 00 00000000 00000000
wr 00c 01234567 0 00000000 00000000 0 00 00000000 00000000
wr 000 00000005 0 00000000 00000000 0 00 00000000 00000000
wt 000 00000001 0 00000000 00000000 0 0b 01234567 89abcdef
rd 008 89abcdef 0 00000000 00000000 0 00 00000000 00000000
rd 00c 01234567 0 00000000 00000000 0 00 00000000 00000000
rd 000 00000005 0 00000000 00000000 0 00 00000000 00000000
wr 000 00000007 0 00000000 00000000 0 00 00000000 00000000
wt 000 00000001 0 00000000 00000000 0 0f 01234567 89abcdef
rd 000 00000007 0 00000000 00000000 0 00 00000000 00000000
rd 004 00000000 0 00000000 00000000 0 00 00000000 00000000
rd 010 cafef00d 0 deadbeef cafef00d 0 00 00000000 00000000
rd 014 deadbeef 0 deadbeef cafef00d 0 00 00000000 00000000
rd 010 2468ace0 0 13579bdf 2468ace0 0 00 00000000 00000000
rd 014 13579bdf 0 13579bdf 2468ace0 0 00 00000000 00000000
wr 800 11111111 0 13579bdf 2468ace0 0 00 00000000 00000000
wr 804 22222222 0 13579bdf 2468ace0 0 00 00000000 00000000
wr 9fc 33333333 0 13579bdf 2468ace0 0 00 00000000 00000000
wr ffc 44444444 0 13579bdf 2468ace0 0 00 00000000 00000000
mc 800 11111111 0 13579bdf 2468ace0 0 00 00000000 00000000
mc 804 22222222 0 13579bdf 2468ace0 0 00 00000000 00000000
mc 9fc 33333333 0 13579bdf 2468ace0 0 00 00000000 00000000
mc ffc 44444444 0 13579bdf 2468ace0 0 00 00000000 00000000
rd 800 11111111 0 13579bdf 2468ace0 0 00 00000000 00000000
rd 9fc 33333333 0 13579bdf 2468ace0 0 00 00000000 00000000
rd ffc 44444444 0 13579bdf 2468ace0 0 00 00000000 00000000
rd 808 cafe0002 0 13579bdf 2468ace0 0 00 00000000 00000000
wr 01c 00000001 0 13579bdf 2468ace0 0 00 00000000 00000000
rd 040 00000000 1 13579bdf 2468ace0 0 00 00000000 00000000
wt 000 00000001 0 13579bdf 2468ace0 0 4f 01234567 89abcdef
wr 020 00000001 0 13579bdf 2468ace0 0 00 00000000 00000000
wt 000 00000001 0 13579bdf 2468ace0 0 0f 01234567 89abcdef
wr 014 12345678 1 13579bdf 2468ace0 0 00 00000000 00000000
rd 020 00000001 0 13579bdf 2468ace0 0 00 00000000 00000000
rd 014 13579bdf 0 13579bdf 2468ace0 0 00 00000000 00000000
wr 020 00000001 0 13579bdf 2468ace0 0 00 00000000 00000000
rd 020 00000000 0 13579bdf 2468ace0 0 00 00000000 00000000
wr 01c 00000003 0 13579bdf 2468ace0 0 00 00000000 00000000
rd 01c 00000003 0 13579bdf 2468ace0 0 00 00000000 00000000
wr 018 00000001 0 13579bdf 2468ace0 0 00 00000000 00000000
wt 000 00000001 0 13579bdf 2468ace0 0 9f 01234567 89abcdef
rd 018 00000001 0 13579bdf 2468ace0 0 00 00000000 00000000
rd 020 00000002 0 13579bdf 2468ace0 0 00 00000000 00000000
wr 018 00000000 0 13579bdf 2468ace0 0 00 00000000 00000000
wt 000 00000001 0 13579bdf 2468ace0 0 8f 01234567 89abcdef
wr 020 00000002 0 13579bdf 2468ace0 0 00 00000000 00000000
wt 000 00000001 0 13579bdf 2468ace0 0 0f 01234567 89abcdef
wr 004 00000001 0 13579bdf 2468ace0 1 00 00000000 00000000
wt 000 00000028 0 13579bdf 2468ace0 1 0e 01234567 89abcdef
po 000 00000012 0 13579bdf 2468ace0 0 2e 01234567 89abcdef
rd 004 00000001 0 13579bdf 2468ace0 0 00 00000000 00000000
wt 000 00000001 0 13579bdf 2468ace0 0 2e 01234567 89abcdef

//--- soc_ifc_top.f
hw/soc_ifc_pkg.sv
hw/mbox_pkg.sv
hw/soc_ifc_regs.sv
hw/soc_ifc_boot_fsm.sv
hw/mbox_sram_ctrl.sv
hw/soc_ifc_top.sv
verif/soc_ifc_props.sv
verif/soc_ifc_tb.sv

//--- Makefile
# Verilator flow for the SoC interface block

VERILATOR ?= verilator
TOP       ?= soc_ifc_tb
RTL_TOP   ?= soc_ifc_top
FILELIST  ?= soc_ifc_top.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --timing --assert
PASS_MSG  ?= STATUS: PASS

RTL_SRCS := $(shell grep '^hw/' $(FILELIST))

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only --top-module $(RTL_TOP) $(RTL_SRCS)
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		-Mdir $(BUILD_DIR) -o $(TOP)
	@out="$$(./$(BUILD_DIR)/$(TOP))"; echo "$$out"; \
		echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
